// ==== design/ex_settings.svh ====
`ifndef EX_SETTINGS_SVH
`define EX_SETTINGS_SVH

// data path and address width
`define EX_XLEN 64

`define EX_INST_W 32

// destination register index
`define EX_REG_IDX_W 5

// alu opcode field
`define EX_ALU_OP_W 5

// counts the 64 shift-add steps
`define EX_MUL_CNT_W 7

`endif

// ==== design/ex_pkg.sv ====
`default_nettype none

`include "ex_settings.svh"

package ex_pkg;

	typedef logic [`EX_XLEN-1:0] xlen_t;
	typedef logic [`EX_XLEN-1:0] addr_t;
	typedef logic [`EX_INST_W-1:0] inst_t;
	typedef logic [`EX_REG_IDX_W-1:0] reg_idx_t;
	typedef logic [12:1] bimm_t; // branch offset, bit 0 implied zero

	typedef enum logic [`EX_ALU_OP_W-1:0] {
		op_add   = 5'd0,
		op_addw  = 5'd1,
		op_sll   = 5'd2,
		op_sllw  = 5'd3,
		op_sra   = 5'd4,
		op_sraw  = 5'd5,
		op_srl   = 5'd6,
		op_srlw  = 5'd7,
		op_and   = 5'd8,
		op_or    = 5'd9,
		op_xor   = 5'd10,
		op_slt   = 5'd11, // signed less than
		op_sltu  = 5'd12,
		op_eq    = 5'd13,
		op_ne    = 5'd14,
		op_ge    = 5'd15, // signed greater or equal
		op_geu   = 5'd16,
		op_sub   = 5'd17,
		op_subw  = 5'd18,
		op_mul   = 5'd19, // low 64 bits
		op_mulh  = 5'd20, // signed x signed, high half
		op_mulhu = 5'd21, // unsigned, high half
		op_mulw  = 5'd22,
		op_none  = 5'd31
	} alu_op_e;

	typedef enum logic [1:0] {
		mul_idle,
		mul_run,
		mul_done
	} mul_state_e;

endpackage

`default_nettype wire

// ==== design/ex_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_alu import ex_pkg::*; (
	input  alu_op_e op,
	input  xlen_t   src_a,
	input  xlen_t   src_b,
	output xlen_t   alu_result
);

	logic [5:0]  shamt;
	logic [4:0]  shamt_w;
	logic [31:0] word_res;
	logic        is_word;

	assign shamt   = src_b[5:0];
	assign shamt_w = src_b[4:0]; // word shifts use 5 bits

	// 32-bit forms, sign-extended below
	always_comb begin
		word_res = '0;
		is_word  = 1'b1;
		case (op)
			op_addw: begin
				word_res = src_a[31:0] + src_b[31:0];
			end
			op_sllw: begin
				word_res = src_a[31:0] << shamt_w;
			end
			op_sraw: begin
				word_res = $signed(src_a[31:0]) >>> shamt_w;
			end
			op_srlw: begin
				word_res = src_a[31:0] >> shamt_w;
			end
			op_subw: begin
				word_res = src_a[31:0] - src_b[31:0];
			end
			default: begin
				is_word = 1'b0;
			end
		endcase
	end

	always_comb begin
		if (is_word) begin
			alu_result = {{32{word_res[31]}}, word_res};
		end else begin
			case (op)
				op_add: begin
					alu_result = src_a + src_b;
				end
				op_sub: begin
					alu_result = src_a - src_b;
				end
				op_sll: begin
					alu_result = src_a << shamt;
				end
				op_sra: begin
					alu_result = $signed(src_a) >>> shamt;
				end
				op_srl: begin
					alu_result = src_a >> shamt;
				end
				op_and: begin
					alu_result = src_a & src_b;
				end
				op_or: begin
					alu_result = src_a | src_b;
				end
				op_xor: begin
					alu_result = src_a ^ src_b;
				end
				op_slt: begin
					alu_result = xlen_t'($signed(src_a) < $signed(src_b));
				end
				op_sltu: begin
					alu_result = xlen_t'(src_a < src_b);
				end
				op_eq: begin
					alu_result = xlen_t'(src_a == src_b);
				end
				op_ne: begin
					alu_result = xlen_t'(src_a != src_b); // also drives bne
				end
				op_ge: begin
					alu_result = xlen_t'($signed(src_a) >= $signed(src_b));
				end
				op_geu: begin
					alu_result = xlen_t'(src_a >= src_b);
				end
				default: begin
					alu_result = '0; // multiply and unused codes
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== design/ex_mul.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ex_settings.svh"

module ex_mul import ex_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       mul_start,
	input  alu_op_e    op,
	input  xlen_t      src_a,
	input  xlen_t      src_b,
	input  logic       accept,
	output mul_state_e mul_state,
	output xlen_t      mul_result
);

	localparam logic [`EX_MUL_CNT_W-1:0] last_cnt = `EX_MUL_CNT_W'(`EX_XLEN - 1);

	logic [2*`EX_XLEN-1:0] mcand;
	logic [2*`EX_XLEN-1:0] acc;
	logic [2*`EX_XLEN-1:0] acc_next;
	xlen_t                 mplier;
	xlen_t                 mag_a;
	xlen_t                 mag_b;
	logic [`EX_MUL_CNT_W-1:0] cnt;
	logic                  sgn;
	logic                  neg_q;
	alu_op_e               op_q;

	// only mulh treats both operands as signed
	assign sgn   = (op == op_mulh);
	assign mag_a = (sgn && src_a[`EX_XLEN-1]) ? -src_a : src_a;
	assign mag_b = (sgn && src_b[`EX_XLEN-1]) ? -src_b : src_b;

	assign acc_next = acc + (mplier[0] ? mcand : '0);

	always_ff @(posedge clk) begin
		if (reset) begin
			mul_state <= mul_idle;
			cnt       <= '0;
		end else begin
			case (mul_state)
				mul_idle: begin
					if (mul_start) begin
						mul_state <= mul_run;
						cnt       <= '0;
					end
				end
				mul_run: begin
					cnt <= cnt + 1'b1;
					if (cnt == last_cnt) begin
						mul_state <= mul_done;
					end
				end
				mul_done: begin
					if (accept) begin
						mul_state <= mul_idle; // result taken by the stage
					end
				end
				default: begin
					mul_state <= mul_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (mul_state == mul_idle && mul_start) begin
			mcand  <= {{`EX_XLEN{1'b0}}, mag_a};
			mplier <= mag_b;
			acc    <= '0;
			neg_q  <= sgn & (src_a[`EX_XLEN-1] ^ src_b[`EX_XLEN-1]);
			op_q   <= op;
		end else if (mul_state == mul_run) begin
			mcand  <= mcand << 1;
			mplier <= mplier >> 1;
			// fix the sign on the last step
			acc    <= (cnt == last_cnt && neg_q) ? -acc_next : acc_next;
		end
	end

	always_comb begin
		case (op_q)
			op_mul:            mul_result = acc[`EX_XLEN-1:0];
			op_mulh, op_mulhu: mul_result = acc[2*`EX_XLEN-1:`EX_XLEN];
			op_mulw:           mul_result = {{(`EX_XLEN-32){acc[31]}}, acc[31:0]};
			default:           mul_result = '0;
		endcase
	end

	// upstream holds the multiply until it is accepted
	a_op_held: assert property (@(posedge clk) disable iff (reset)
		mul_state != mul_idle |-> op == op_q);

endmodule

`default_nettype wire

// ==== design/ex_issue.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ex_settings.svh"

module ex_issue import ex_pkg::*; (
	input  alu_op_e    op,
	input  logic       in_valid,
	input  logic       mem_w_en,
	input  logic       wb_sel,
	input  logic       brch,
	input  addr_t      pc_in,
	input  bimm_t      bimm,
	input  xlen_t      alu_result,
	input  mul_state_e mul_state,
	input  xlen_t      mul_result,
	input  logic       aw_ready,
	input  logic       ar_ready,
	input  logic       out_ready,
	output logic       in_ready,
	output logic       accept,
	output logic       mul_start,
	output logic       aw_valid,
	output logic       ar_valid,
	output xlen_t      ex_result,
	output logic       br_taken,
	output addr_t      br_target,
	output logic       flush
);

	logic is_mul;
	logic is_store;
	logic is_load;
	logic class_ready;
	logic mul_stall;

	assign is_mul   = op inside {op_mul, op_mulh, op_mulhu, op_mulw};
	assign is_store = mem_w_en;
	assign is_load  = wb_sel; // writeback from memory data

	always_comb begin
		if (is_store) begin
			class_ready = aw_ready;
		end else if (is_load) begin
			class_ready = ar_ready;
		end else begin
			class_ready = out_ready;
		end
	end

	assign mul_stall = is_mul && (mul_state != mul_done);
	assign in_ready  = mul_stall ? 1'b0 : class_ready;
	assign accept    = in_valid & in_ready;
	assign mul_start = is_mul & in_valid & (mul_state == mul_idle);

	assign aw_valid = in_valid & is_store;
	assign ar_valid = in_valid & is_load;

	assign ex_result = is_mul ? mul_result : alu_result;

	// compare result selects the branch
	assign br_taken  = brch & (ex_result != '0);
	assign br_target = pc_in + {{(`EX_XLEN-$bits(bimm_t)-1){bimm[12]}}, bimm, 1'b0};
	assign flush     = br_taken & accept;

	// decode never marks one instruction as both load and store
	always_comb begin
		a_one_request: assert final (!(aw_valid && ar_valid));
	end

endmodule

`default_nettype wire

// ==== design/ex_pipe_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_pipe_reg import ex_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  logic     accept,
	input  logic     out_ready,
	input  addr_t    pc_in,
	input  inst_t    inst_in,
	input  logic     mem_w_en,
	input  logic     wb_sel,
	input  logic     reg_w_en,
	input  reg_idx_t rdest,
	input  xlen_t    rt_data,
	input  xlen_t    ex_result,
	output logic     out_valid,
	output addr_t    out_pc,
	output inst_t    out_inst,
	output logic     out_mem_w_en,
	output logic     out_wb_sel,
	output logic     out_reg_w_en,
	output reg_idx_t out_rdest,
	output xlen_t    out_rt_data,
	output xlen_t    out_result
);

	logic bubble;

	assign bubble = out_ready & ~accept; // next stage drained, nothing new

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid    <= 1'b0;
			out_mem_w_en <= 1'b0;
			out_wb_sel   <= 1'b0;
			out_reg_w_en <= 1'b0;
		end else if (accept) begin
			out_valid    <= 1'b1;
			out_mem_w_en <= mem_w_en;
			out_wb_sel   <= wb_sel;
			out_reg_w_en <= reg_w_en;
		end else if (bubble) begin
			out_valid    <= 1'b0;
			out_mem_w_en <= 1'b0;
			out_wb_sel   <= 1'b0;
			out_reg_w_en <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			out_pc      <= pc_in;
			out_inst    <= inst_in;
			out_rdest   <= rdest;
			out_rt_data <= rt_data;
			out_result  <= ex_result;
		end else if (bubble) begin
			out_inst  <= '0;
			out_rdest <= '0;
		end
	end

	// a stalled memory stage sees a frozen instruction
	a_hold_stalled: assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=>
			$stable(out_valid) && $stable(out_pc) && $stable(out_inst) &&
			$stable(out_mem_w_en) && $stable(out_wb_sel) && $stable(out_reg_w_en) &&
			$stable(out_rdest) && $stable(out_rt_data) && $stable(out_result));

endmodule

`default_nettype wire

// ==== design/ex_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_stage import ex_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  logic     in_valid,
	input  alu_op_e  op,
	input  xlen_t    src_a,
	input  xlen_t    src_b,
	input  addr_t    pc_in,
	input  inst_t    inst_in,
	input  logic     brch,
	input  logic     mem_w_en,
	input  logic     wb_sel,
	input  logic     reg_w_en,
	input  reg_idx_t rdest,
	input  xlen_t    rt_data,
	input  bimm_t    bimm,
	input  logic     aw_ready,
	input  logic     ar_ready,
	input  logic     out_ready,
	output logic     in_ready,
	output logic     aw_valid,
	output logic     ar_valid,
	output addr_t    mem_addr,
	output xlen_t    w_data,
	output logic     br_taken,
	output addr_t    br_target,
	output logic     flush,
	output logic     out_valid,
	output addr_t    out_pc,
	output inst_t    out_inst,
	output logic     out_mem_w_en,
	output logic     out_wb_sel,
	output logic     out_reg_w_en,
	output reg_idx_t out_rdest,
	output xlen_t    out_rt_data,
	output xlen_t    out_result
);

	xlen_t      alu_result;
	xlen_t      mul_result;
	xlen_t      ex_result;
	mul_state_e mul_state;
	logic       mul_start;
	logic       accept;

	assign mem_addr = alu_result; // one address for read and write
	assign w_data   = rt_data;

	ex_alu ex_alu_i (
		.op         (op),
		.src_a      (src_a),
		.src_b      (src_b),
		.alu_result (alu_result)
	);

	ex_mul ex_mul_i (
		.clk        (clk),
		.reset      (reset),
		.mul_start  (mul_start),
		.op         (op),
		.src_a      (src_a),
		.src_b      (src_b),
		.accept     (accept),
		.mul_state  (mul_state),
		.mul_result (mul_result)
	);

	ex_issue ex_issue_i (
		.op         (op),
		.in_valid   (in_valid),
		.mem_w_en   (mem_w_en),
		.wb_sel     (wb_sel),
		.brch       (brch),
		.pc_in      (pc_in),
		.bimm       (bimm),
		.alu_result (alu_result),
		.mul_state  (mul_state),
		.mul_result (mul_result),
		.aw_ready   (aw_ready),
		.ar_ready   (ar_ready),
		.out_ready  (out_ready),
		.in_ready   (in_ready),
		.accept     (accept),
		.mul_start  (mul_start),
		.aw_valid   (aw_valid),
		.ar_valid   (ar_valid),
		.ex_result  (ex_result),
		.br_taken   (br_taken),
		.br_target  (br_target),
		.flush      (flush)
	);

	ex_pipe_reg ex_pipe_reg_i (
		.clk          (clk),
		.reset        (reset),
		.accept       (accept),
		.out_ready    (out_ready),
		.pc_in        (pc_in),
		.inst_in      (inst_in),
		.mem_w_en     (mem_w_en),
		.wb_sel       (wb_sel),
		.reg_w_en     (reg_w_en),
		.rdest        (rdest),
		.rt_data      (rt_data),
		.ex_result    (ex_result),
		.out_valid    (out_valid),
		.out_pc       (out_pc),
		.out_inst     (out_inst),
		.out_mem_w_en (out_mem_w_en),
		.out_wb_sel   (out_wb_sel),
		.out_reg_w_en (out_reg_w_en),
		.out_rdest    (out_rdest),
		.out_rt_data  (out_rt_data),
		.out_result   (out_result)
	);

endmodule

`default_nettype wire

// ==== tests/ex_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_clk_gen (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk; // 100 ns period
	end

	initial begin
		reset = 1'b1;
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
	end

endmodule

`default_nettype wire

// ==== tests/ex_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_tb import ex_pkg::*; ();

	localparam int max_rows   = 96;
	localparam int mul_cycles = 1 + 64; // start edge plus the run steps
	localparam int wait_limit = 200;

	logic     clk;
	logic     reset;
	logic     in_valid;
	alu_op_e  op;
	xlen_t    src_a;
	xlen_t    src_b;
	addr_t    pc_in;
	inst_t    inst_in;
	logic     brch;
	logic     mem_w_en;
	logic     wb_sel;
	logic     reg_w_en;
	reg_idx_t rdest;
	xlen_t    rt_data;
	bimm_t    bimm;
	logic     aw_ready;
	logic     ar_ready;
	logic     out_ready;
	logic     in_ready;
	logic     aw_valid;
	logic     ar_valid;
	addr_t    mem_addr;
	xlen_t    w_data;
	logic     br_taken;
	addr_t    br_target;
	logic     flush;
	logic     out_valid;
	addr_t    out_pc;
	inst_t    out_inst;
	logic     out_mem_w_en;
	logic     out_wb_sel;
	logic     out_reg_w_en;
	reg_idx_t out_rdest;
	xlen_t    out_rt_data;
	xlen_t    out_result;

	string   row_name [max_rows];
	alu_op_e row_op [max_rows];
	xlen_t   row_a [max_rows];
	xlen_t   row_b [max_rows];
	logic    row_brch [max_rows];
	logic    row_store [max_rows];
	logic    row_load [max_rows];
	bimm_t   row_bimm [max_rows];
	logic    row_late [max_rows]; // class ready starts low
	logic    row_hold [max_rows]; // out_ready low after accept
	xlen_t   exp_result [max_rows];
	logic    exp_taken [max_rows];
	addr_t   exp_target [max_rows];
	int      n_rows;
	int      error_count;
	integer  seed;

	ex_clk_gen ex_clk_gen_i (
		.clk   (clk),
		.reset (reset)
	);

	ex_stage ex_stage_i (.*);

	function automatic xlen_t sext_word(input logic [31:0] w);
		return xlen_t'($signed(w));
	endfunction

	function automatic xlen_t ref_result(input alu_op_e code, input xlen_t a, input xlen_t b);
		logic [127:0] prod_u;
		logic [127:0] prod_s;
		logic         lt_s;
		xlen_t        r;
		prod_u = {64'd0, a} * {64'd0, b};
		prod_s = $signed({{64{a[63]}}, a}) * $signed({{64{b[63]}}, b});
		lt_s   = (a[63] != b[63]) ? a[63] : (a < b); // sign bits decide first
		case (code)
			op_add:   r = a + b;
			op_addw:  r = sext_word(a[31:0] + b[31:0]);
			op_sll:   r = a << b[5:0];
			op_sllw:  r = sext_word(a[31:0] << b[4:0]);
			op_sra:   r = $signed(a) >>> b[5:0];
			op_sraw:  r = sext_word($signed(a[31:0]) >>> b[4:0]);
			op_srl:   r = a >> b[5:0];
			op_srlw:  r = sext_word(a[31:0] >> b[4:0]);
			op_and:   r = a & b;
			op_or:    r = a | b;
			op_xor:   r = a ^ b;
			op_slt:   r = xlen_t'(lt_s);
			op_sltu:  r = xlen_t'(a < b);
			op_eq:    r = xlen_t'(a == b);
			op_ne:    r = xlen_t'(a != b);
			op_ge:    r = xlen_t'(!lt_s);
			op_geu:   r = xlen_t'(!(a < b));
			op_sub:   r = a - b;
			op_subw:  r = sext_word(a[31:0] - b[31:0]);
			op_mul:   r = prod_u[63:0];
			op_mulh:  r = prod_s[127:64];
			op_mulhu: r = prod_u[127:64];
			op_mulw:  r = sext_word(prod_u[31:0]);
			default:  r = '0;
		endcase
		return r;
	endfunction

	function automatic addr_t ref_target(input addr_t pc, input bimm_t imm);
		logic signed [63:0] offset;
		offset = 64'($signed(imm));
		return pc + addr_t'(offset + offset); // offset counts halfwords
	endfunction

	function automatic addr_t row_pc(input int i);
		return 64'h0000_0000_8000_0000 + (xlen_t'(i) << 2);
	endfunction

	function automatic inst_t row_inst(input int i);
		return inst_t'(32'h0000_0013 | (i << 7));
	endfunction

	function automatic xlen_t row_rt(input int i);
		return row_b[i] ^ 64'h5a5a_5a5a_a5a5_a5a5;
	endfunction

	function automatic xlen_t rnd64();
		return {$random(seed), $random(seed)};
	endfunction

	task automatic check_equal(input string name, input xlen_t expected, input xlen_t actual);
		if (expected !== actual) begin
			error_count++;
			$display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
			$display(">>> FAIL");
			$fatal(1, "value check failed");
		end
	endtask

	task automatic report_timeout(input string what);
		error_count++;
		$display("Timeout: %s", what);
		$display(">>> FAIL");
		$fatal(1, "wait timed out");
	endtask

	task automatic add_row(input string name, input alu_op_e code, input xlen_t a,
		input xlen_t b, input logic br, input logic store, input logic load,
		input bimm_t imm, input logic late, input logic hold);
		row_name[n_rows]   = name;
		row_op[n_rows]     = code;
		row_a[n_rows]      = a;
		row_b[n_rows]      = b;
		row_brch[n_rows]   = br;
		row_store[n_rows]  = store;
		row_load[n_rows]   = load;
		row_bimm[n_rows]   = imm;
		row_late[n_rows]   = late;
		row_hold[n_rows]   = hold;
		exp_result[n_rows] = ref_result(code, a, b);
		exp_taken[n_rows]  = br && (exp_result[n_rows] != '0);
		exp_target[n_rows] = ref_target(row_pc(n_rows), imm);
		n_rows++;
	endtask

	task automatic build_table();
		alu_op_e code;
		n_rows = 0;
		for (int k = 0; k <= 18; k++) begin
			code = alu_op_e'(5'(k));
			add_row($sformatf("%s fixed0", code.name()), code, 64'hffff_ffff_8000_0001,
				64'h0000_0000_0000_0021, 1'b0, 1'b0, 1'b0, 12'h000, 1'b0, (k % 5) == 2);
			add_row($sformatf("%s fixed1", code.name()), code, 64'h0000_0000_7fff_ffff,
				64'hffff_ffff_ffff_ffff, 1'b0, 1'b0, 1'b0, 12'h000, 1'b0, 1'b0);
			add_row($sformatf("%s random", code.name()), code, rnd64(), rnd64(),
				1'b0, 1'b0, 1'b0, 12'h000, 1'b0, 1'b0);
		end
		for (int k = 19; k <= 22; k++) begin
			code = alu_op_e'(5'(k));
			add_row($sformatf("%s neg pos", code.name()), code, 64'hffff_ffff_ffff_fff9,
				64'h0000_0001_2345_6789, 1'b0, 1'b0, 1'b0, 12'h000, 1'b0, 1'b0);
			add_row($sformatf("%s neg neg", code.name()), code, 64'h8000_0000_0000_0003,
				64'hc000_0000_0000_0005, 1'b0, 1'b0, 1'b0, 12'h000, 1'b0, 1'b0);
			add_row($sformatf("%s random", code.name()), code, rnd64(), rnd64(),
				1'b0, 1'b0, 1'b0, 12'h000, 1'b0, 1'b0);
		end
		add_row("beq taken back", op_eq, 64'h1234, 64'h1234, 1'b1, 1'b0, 1'b0,
			12'hff0, 1'b0, 1'b0);
		add_row("bne not taken", op_ne, 64'h5, 64'h5, 1'b1, 1'b0, 1'b0, 12'h010, 1'b0, 1'b0);
		add_row("blt taken fwd", op_slt, 64'hffff_ffff_ffff_fffd, 64'h2, 1'b1, 1'b0, 1'b0,
			12'h07f, 1'b0, 1'b0);
		add_row("add out_ready late", op_add, rnd64(), rnd64(), 1'b0, 1'b0, 1'b0,
			12'h000, 1'b1, 1'b1);
		add_row("store", op_add, 64'h0000_0000_0001_0000, 64'h28, 1'b0, 1'b1, 1'b0,
			12'h000, 1'b1, 1'b0);
		add_row("load", op_add, 64'h0000_0000_0002_0000, 64'h40, 1'b0, 1'b0, 1'b1,
			12'h000, 1'b1, 1'b0);
	endtask

	task automatic drive_row(input int i);
		in_valid  = 1'b1;
		op        = row_op[i];
		src_a     = row_a[i];
		src_b     = row_b[i];
		pc_in     = row_pc(i);
		inst_in   = row_inst(i);
		brch      = row_brch[i];
		mem_w_en  = row_store[i];
		wb_sel    = row_load[i];
		reg_w_en  = !row_store[i];
		rdest     = reg_idx_t'(i);
		rt_data   = row_rt(i);
		bimm      = row_bimm[i];
		aw_ready  = !(row_late[i] && row_store[i]);
		ar_ready  = !(row_late[i] && row_load[i]);
		out_ready = !(row_late[i] && !row_store[i] && !row_load[i]);
	endtask

	task automatic check_outputs(input int i);
		string n;
		n = row_name[i];
		check_equal({n, " out_valid"}, 64'd1, xlen_t'(out_valid));
		check_equal({n, " out_result"}, exp_result[i], out_result);
		check_equal({n, " out_pc"}, row_pc(i), out_pc);
		check_equal({n, " out_inst"}, xlen_t'(row_inst(i)), xlen_t'(out_inst));
		check_equal({n, " out_mem_w_en"}, xlen_t'(row_store[i]), xlen_t'(out_mem_w_en));
		check_equal({n, " out_wb_sel"}, xlen_t'(row_load[i]), xlen_t'(out_wb_sel));
		check_equal({n, " out_reg_w_en"}, xlen_t'(!row_store[i]), xlen_t'(out_reg_w_en));
		check_equal({n, " out_rdest"}, xlen_t'(i % 32), xlen_t'(out_rdest));
		check_equal({n, " out_rt_data"}, row_rt(i), out_rt_data);
	endtask

	task automatic run_row(input int i);
		int    waited;
		logic  is_mul;
		string n;
		n      = row_name[i];
		is_mul = (row_op[i] >= op_mul) && (row_op[i] <= op_mulw);
		@(posedge clk);
		#1;
		drive_row(i);
		@(negedge clk);
		if (!is_mul) begin
			check_equal({n, " in_ready"}, xlen_t'(!row_late[i]), xlen_t'(in_ready));
		end
		if (row_late[i]) begin
			@(posedge clk);
			#1;
			aw_ready  = 1'b1;
			ar_ready  = 1'b1;
			out_ready = 1'b1;
			@(negedge clk);
		end
		waited = 0;
		while (!in_ready) begin
			if (waited > wait_limit) begin
				report_timeout({n, ": in_ready never rose"});
			end else begin
				@(negedge clk);
				waited++;
			end
		end
		if (is_mul) begin
			check_equal({n, " stall cycles"}, xlen_t'(mul_cycles), xlen_t'(waited));
		end
		check_equal({n, " aw_valid"}, xlen_t'(row_store[i]), xlen_t'(aw_valid));
		check_equal({n, " ar_valid"}, xlen_t'(row_load[i]), xlen_t'(ar_valid));
		if (row_store[i] || row_load[i]) begin
			check_equal({n, " mem_addr"}, exp_result[i], mem_addr);
			check_equal({n, " w_data"}, row_rt(i), w_data);
		end
		check_equal({n, " br_taken"}, xlen_t'(exp_taken[i]), xlen_t'(br_taken));
		check_equal({n, " br_target"}, exp_target[i], br_target);
		check_equal({n, " flush"}, xlen_t'(exp_taken[i]), xlen_t'(flush));
		@(posedge clk); // accept edge
		#1;
		in_valid  = 1'b0;
		out_ready = !row_hold[i];
		@(negedge clk);
		check_outputs(i);
		if (row_hold[i]) begin
			repeat (3) begin
				@(negedge clk);
				check_equal({n, " in_ready held"}, 64'd0, xlen_t'(in_ready));
				check_outputs(i);
			end
			@(posedge clk);
			#1;
			out_ready = 1'b1;
		end
	endtask

	initial begin
		int waited;
		error_count = 0;
		seed        = 71;
		in_valid    = 1'b0;
		op          = op_none;
		src_a       = '0;
		src_b       = '0;
		pc_in       = '0;
		inst_in     = '0;
		brch        = 1'b0;
		mem_w_en    = 1'b0;
		wb_sel      = 1'b0;
		reg_w_en    = 1'b0;
		rdest       = '0;
		rt_data     = '0;
		bimm        = '0;
		aw_ready    = 1'b1;
		ar_ready    = 1'b1;
		out_ready   = 1'b1;
		build_table();
		@(negedge clk);
		waited = 0;
		while (reset) begin
			if (waited > 20) begin
				report_timeout("reset was never released");
			end else begin
				@(negedge clk);
				waited++;
			end
		end
		check_equal("reset out_valid", 64'd0, xlen_t'(out_valid));
		check_equal("reset flush", 64'd0, xlen_t'(flush));
		check_equal("reset out_mem_w_en", 64'd0, xlen_t'(out_mem_w_en));
		check_equal("reset out_wb_sel", 64'd0, xlen_t'(out_wb_sel));
		check_equal("reset out_reg_w_en", 64'd0, xlen_t'(out_reg_w_en));
		for (int i = 0; i < n_rows; i++) begin
			run_row(i);
		end
		if (error_count == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+design
design/ex_pkg.sv
design/ex_alu.sv
design/ex_mul.sv
design/ex_issue.sv
design/ex_pipe_reg.sv
design/ex_stage.sv
tests/ex_clk_gen.sv
tests/ex_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -f sim.f \
	--top-module ex_tb -o ex_tb > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/ex_tb > sim.log 2>&1
cat sim.log

grep -q ">>> FAIL" sim.log && exit 1
grep -q ">>> PASS" sim.log || exit 1
exit 0
